// File: Bender.yml
package:
  name: l2_front

sources:
  - design/l2_pkg.sv
  - design/l2_restart_if.sv
  - design/l2_miss_queue.sv
  - design/l2_restart_unit.sv
  - design/l2_cache_arb.sv
  - design/l2_front.sv
  - target: simulation
    files:
      - sim/l2_front_tb.sv

// File: all.f
design/l2_pkg.sv
design/l2_restart_if.sv
design/l2_miss_queue.sv
design/l2_restart_unit.sv
design/l2_cache_arb.sv
design/l2_front.sv
sim/l2_front_tb.sv

// File: design/l2_cache_arb.sv
// Chooses what enters the tag stage each cycle: a restarted miss with its
// fill line, or a core request. Restarts always win and ignore the stall;
// core requests are acked only with no stall and no restart.

`timescale 1ns/10ps

module l2_cache_arb (
	input logic clk,
	input logic rst,
	input logic stall_pipeline,
	input logic pci_valid,
	output logic pci_ack,
	input l2_pkg::l2_req_t pci_req,
	l2_restart_if.dst rst_in,
	output logic arb_pci_valid,
	output l2_pkg::l2_req_t arb_pci_req,
	output logic arb_has_sm_data,
	output logic [l2_pkg::LINE_BITS-1:0] arb_sm_data,
	output logic [1:0] arb_sm_fill_way
);

	// the core holds pci_valid until it sees this strobe
	assign pci_ack = pci_valid && !stall_pipeline && !rst_in.data_ready;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			arb_pci_valid <= 1'b0;
			arb_has_sm_data <= 1'b0;
		end
		else
		begin
			arb_pci_valid <= rst_in.data_ready || pci_ack;
			arb_has_sm_data <= rst_in.data_ready;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst_in.data_ready)
		begin
			arb_pci_req <= rst_in.req;
			arb_sm_data <= rst_in.load_buffer;
			arb_sm_fill_way <= rst_in.fill_way;
		end
		else
		begin
			// fill way only matters with has_sm_data and keeps its value here
			arb_pci_req <= pci_req;
			arb_sm_data <= '0;
		end
	end

	// a restart cycle must lock out the core and show up as a fill next cycle
	a_restart_wins: assert property (
		@(posedge clk) disable iff (rst)
		rst_in.data_ready |-> !pci_ack ##1 (arb_pci_valid && arb_has_sm_data)
	) else $error("arbiter: restart not taken ahead of core request");

endmodule

// File: design/l2_front.sv
// Top of the L2 request front end. Packs the core and miss field ports into
// request records, wires the miss queue, restart unit and arbiter together,
// and unpacks the arbiter record onto plain output ports.

`timescale 1ns/10ps

module l2_front (
	input logic clk,
	input logic rst,
	input logic stall_pipeline,

	// core side
	input logic pci_valid,
	output logic pci_ack,
	input logic [1:0] pci_unit,
	input logic [1:0] pci_strand,
	input logic [2:0] pci_op,
	input logic [1:0] pci_way,
	input logic [l2_pkg::ADDR_BITS-1:0] pci_address,
	input logic [l2_pkg::LINE_BITS-1:0] pci_data,
	input logic [l2_pkg::MASK_BITS-1:0] pci_mask,

	// misses returning from later stages
	input logic miss_valid,
	output logic miss_full,
	input logic [1:0] miss_unit,
	input logic [1:0] miss_strand,
	input logic [2:0] miss_op,
	input logic [1:0] miss_way,
	input logic [l2_pkg::ADDR_BITS-1:0] miss_address,
	input logic [l2_pkg::LINE_BITS-1:0] miss_data,
	input logic [l2_pkg::MASK_BITS-1:0] miss_mask,

	// system memory
	output logic mem_req_valid,
	output logic [l2_pkg::ADDR_BITS-1:0] mem_req_address,
	input logic mem_req_ack,
	input logic mem_fill_valid,
	input logic [l2_pkg::LINE_BITS-1:0] mem_fill_data,

	// into the tag stage
	output logic arb_pci_valid,
	output logic [1:0] arb_pci_unit,
	output logic [1:0] arb_pci_strand,
	output logic [2:0] arb_pci_op,
	output logic [1:0] arb_pci_way,
	output logic [l2_pkg::ADDR_BITS-1:0] arb_pci_address,
	output logic [l2_pkg::LINE_BITS-1:0] arb_pci_data,
	output logic [l2_pkg::MASK_BITS-1:0] arb_pci_mask,
	output logic arb_has_sm_data,
	output logic [l2_pkg::LINE_BITS-1:0] arb_sm_data,
	output logic [1:0] arb_sm_fill_way
);

	l2_pkg::l2_req_t pci_req;
	l2_pkg::l2_req_t miss_req;
	l2_pkg::l2_req_t head;
	l2_pkg::l2_req_t arb_pci_req;
	logic head_valid;
	logic pop;

	l2_restart_if restart_bus ();

	assign pci_req = '{pci_unit, pci_strand, pci_op, pci_way,
		pci_address, pci_data, pci_mask};
	assign miss_req = '{miss_unit, miss_strand, miss_op, miss_way,
		miss_address, miss_data, miss_mask};

	assign arb_pci_unit = arb_pci_req.unit;
	assign arb_pci_strand = arb_pci_req.strand;
	assign arb_pci_op = arb_pci_req.op;
	assign arb_pci_way = arb_pci_req.way;
	assign arb_pci_address = arb_pci_req.address;
	assign arb_pci_data = arb_pci_req.data;
	assign arb_pci_mask = arb_pci_req.mask;

	l2_miss_queue #(
		.DEPTH(l2_pkg::MISS_QUEUE_DEPTH)
	) miss_queue_i (
		.clk(clk),
		.rst(rst),
		.push(miss_valid),
		.push_req(miss_req),
		.full(miss_full),
		.head_valid(head_valid),
		.head(head),
		.pop(pop)
	);

	l2_restart_unit restart_unit_i (
		.clk(clk),
		.rst(rst),
		.head_valid(head_valid),
		.head(head),
		.pop(pop),
		.mem_req_valid(mem_req_valid),
		.mem_req_address(mem_req_address),
		.mem_req_ack(mem_req_ack),
		.mem_fill_valid(mem_fill_valid),
		.mem_fill_data(mem_fill_data),
		.rst_out(restart_bus.src)
	);

	l2_cache_arb cache_arb_i (
		.clk(clk),
		.rst(rst),
		.stall_pipeline(stall_pipeline),
		.pci_valid(pci_valid),
		.pci_ack(pci_ack),
		.pci_req(pci_req),
		.rst_in(restart_bus.dst),
		.arb_pci_valid(arb_pci_valid),
		.arb_pci_req(arb_pci_req),
		.arb_has_sm_data(arb_has_sm_data),
		.arb_sm_data(arb_sm_data),
		.arb_sm_fill_way(arb_sm_fill_way)
	);

endmodule

// File: design/l2_miss_queue.sv
// In-order queue for requests that missed in the cache and wait for a fill.
// The oldest entry is always presented at head; pop retires it on the clock
// edge. A push while full is dropped.

`timescale 1ns/10ps

module l2_miss_queue #(
	parameter int DEPTH = l2_pkg::MISS_QUEUE_DEPTH
) (
	input logic clk,
	input logic rst,
	input logic push,
	input l2_pkg::l2_req_t push_req,
	output logic full,
	output logic head_valid,
	output l2_pkg::l2_req_t head,
	input logic pop
);

	l2_pkg::l2_req_t entries [DEPTH];

	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH):0] count;
	logic do_push;
	logic do_pop;

	assign full = (count == DEPTH);
	assign head_valid = (count != '0);
	assign head = entries[rd_ptr];

	assign do_push = push && !full;
	assign do_pop = pop && head_valid;

	// pointers wrap naturally since DEPTH is a power of two
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_push)
			entries[wr_ptr] <= push_req;
	end

	// the miss path upstream has no back-pressure of its own
	a_no_push_when_full: assert property (
		@(posedge clk) disable iff (rst) push |-> !full
	) else $error("miss queue: push while full, request dropped");

	a_no_pop_when_empty: assert property (
		@(posedge clk) disable iff (rst) pop |-> head_valid
	) else $error("miss queue: pop while empty");

endmodule

// File: design/l2_pkg.sv
// Shared widths, queue depth and request record for the L2 request front end.
// Compiled ahead of every other design and testbench source.

package l2_pkg;

	// line address with the byte offset already stripped
	localparam int ADDR_BITS = 26;

	// one cache line and its byte enables
	localparam int LINE_BITS = 512;
	localparam int MASK_BITS = LINE_BITS / 8;

	// miss queue entries, any power of two from 2 up
	localparam int MISS_QUEUE_DEPTH = 4;

	// operation codes seen on the core side
	// the front end carries op through and never decodes it
	localparam logic [2:0] OP_LOAD = 3'd0;
	localparam logic [2:0] OP_STORE = 3'd1;

	// one request as it moves from a core or the miss path into the pipeline
	typedef struct packed {
		logic [1:0] unit;
		logic [1:0] strand;
		logic [2:0] op;
		logic [1:0] way;
		logic [ADDR_BITS-1:0] address;
		logic [LINE_BITS-1:0] data;
		logic [MASK_BITS-1:0] mask;
	} l2_req_t;

endpackage

// File: design/l2_restart_if.sv
// Carries one restarted request and its fill line from the restart unit to
// the arbiter. data_ready is a single-cycle pulse; req, load_buffer and
// fill_way are only meaningful while it is high.

`timescale 1ns/10ps

interface l2_restart_if;

	logic data_ready;
	l2_pkg::l2_req_t req;
	logic [l2_pkg::LINE_BITS-1:0] load_buffer;
	logic [1:0] fill_way;

	// restart unit side
	modport src (
		output data_ready,
		output req,
		output load_buffer,
		output fill_way
	);

	// arbiter side
	modport dst (
		input data_ready,
		input req,
		input load_buffer,
		input fill_way
	);

endinterface

// File: design/l2_restart_unit.sv
// Takes the oldest miss, reads its line from system memory and hands the
// request, the line and a fill way to the arbiter as a one-cycle restart.
// The queue entry is popped on the same edge that ends the restart cycle.

`timescale 1ns/10ps

module l2_restart_unit (
	input logic clk,
	input logic rst,
	input logic head_valid,
	input l2_pkg::l2_req_t head,
	output logic pop,
	output logic mem_req_valid,
	output logic [l2_pkg::ADDR_BITS-1:0] mem_req_address,
	input logic mem_req_ack,
	input logic mem_fill_valid,
	input logic [l2_pkg::LINE_BITS-1:0] mem_fill_data,
	l2_restart_if.src rst_out
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_REQUEST,
		S_WAIT_FILL,
		S_RESTART
	} state_t;

	state_t state;
	logic [1:0] fill_way_cnt;
	logic [l2_pkg::LINE_BITS-1:0] fill_line;

	// head stays put until the pop, so its address can drive memory directly
	assign mem_req_valid = (state == S_REQUEST);
	assign mem_req_address = head.address;

	assign pop = (state == S_RESTART);

	assign rst_out.data_ready = (state == S_RESTART);
	assign rst_out.req = head;
	assign rst_out.load_buffer = fill_line;
	assign rst_out.fill_way = fill_way_cnt;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= S_IDLE;
			fill_way_cnt <= 2'd0;
		end
		else
		begin
			case (state)
				S_IDLE:
					if (head_valid)
						state <= S_REQUEST;
				S_REQUEST:
					if (mem_req_ack)
						state <= S_WAIT_FILL;
				S_WAIT_FILL:
					if (mem_fill_valid)
						state <= S_RESTART;
				S_RESTART:
				begin
					// rotating way stands in for a replacement policy
					fill_way_cnt <= fill_way_cnt + 2'd1;
					state <= S_IDLE;
				end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (mem_fill_valid)
			fill_line <= mem_fill_data;
	end

	a_fill_only_when_waiting: assert property (
		@(posedge clk) disable iff (rst) mem_fill_valid |-> state == S_WAIT_FILL
	) else $error("restart unit: memory fill with no read outstanding");

	// request must hold steady until memory takes it
	a_req_held_until_ack: assert property (
		@(posedge clk) disable iff (rst)
		mem_req_valid && !mem_req_ack |=> mem_req_valid && $stable(mem_req_address)
	) else $error("restart unit: memory request dropped before ack");

endmodule

// File: sim/l2_front_tb.sv
// Testbench for the L2 request front end. Drives core requests, misses and a
// memory model with random latency, keeps queues of expected core requests and
// restarts, and checks the DUT with concurrent assertions.

`timescale 1ns/10ps

module l2_front_tb;

	localparam int NUM_TESTS = 6;
	localparam int DEPTH = l2_pkg::MISS_QUEUE_DEPTH;
	localparam int ADDR = l2_pkg::ADDR_BITS;
	localparam int LINE = l2_pkg::LINE_BITS;

	logic clk;
	logic rst;
	logic stall_pipeline;
	logic pci_valid;
	logic miss_valid;
	logic mem_req_ack;
	logic mem_fill_valid;
	logic [LINE-1:0] mem_fill_data;
	l2_pkg::l2_req_t core_drv;
	l2_pkg::l2_req_t miss_drv;
	wire l2_pkg::l2_req_t arb_req;
	wire pci_ack;
	wire miss_full;
	wire mem_req_valid;
	wire [ADDR-1:0] mem_req_address;
	wire arb_pci_valid;
	wire arb_has_sm_data;
	wire [LINE-1:0] arb_sm_data;
	wire [1:0] arb_sm_fill_way;

	// reference model state
	l2_pkg::l2_req_t core_q [$];
	l2_pkg::l2_req_t miss_q [$];
	l2_pkg::l2_req_t exp_core;
	l2_pkg::l2_req_t exp_restart;
	logic [LINE-1:0] exp_line;
	logic [1:0] exp_way;
	logic [1:0] way_next;
	logic [ADDR-1:0] exp_head_addr;
	int model_count;
	logic pop_pending;
	logic push_ok;

	// memory model state
	logic hold_ack;
	logic fill_pending;
	logic [ADDR-1:0] fill_addr;
	int ack_wait;
	int fill_wait;

	int err_count;
	int tests_failed;

	l2_front dut_i (
		.clk(clk), .rst(rst), .stall_pipeline(stall_pipeline),
		.pci_valid(pci_valid), .pci_ack(pci_ack),
		.pci_unit(core_drv.unit), .pci_strand(core_drv.strand), .pci_op(core_drv.op),
		.pci_way(core_drv.way), .pci_address(core_drv.address),
		.pci_data(core_drv.data), .pci_mask(core_drv.mask),
		.miss_valid(miss_valid), .miss_full(miss_full),
		.miss_unit(miss_drv.unit), .miss_strand(miss_drv.strand), .miss_op(miss_drv.op),
		.miss_way(miss_drv.way), .miss_address(miss_drv.address),
		.miss_data(miss_drv.data), .miss_mask(miss_drv.mask),
		.mem_req_valid(mem_req_valid), .mem_req_address(mem_req_address),
		.mem_req_ack(mem_req_ack), .mem_fill_valid(mem_fill_valid),
		.mem_fill_data(mem_fill_data),
		.arb_pci_valid(arb_pci_valid),
		.arb_pci_unit(arb_req.unit), .arb_pci_strand(arb_req.strand),
		.arb_pci_op(arb_req.op), .arb_pci_way(arb_req.way),
		.arb_pci_address(arb_req.address), .arb_pci_data(arb_req.data),
		.arb_pci_mask(arb_req.mask),
		.arb_has_sm_data(arb_has_sm_data), .arb_sm_data(arb_sm_data),
		.arb_sm_fill_way(arb_sm_fill_way)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// every 32-bit word of a memory line carries the full line address
	function automatic logic [LINE-1:0] line_of(input logic [ADDR-1:0] addr);
		logic [LINE-1:0] line;
		for (int i = 0; i < LINE / 32; i++)
			line[i*32 +: 32] = {addr, 6'(i)} ^ 32'hc3a5_9e17;
		return line;
	endfunction

	function automatic l2_pkg::l2_req_t random_req(input logic [2:0] op);
		l2_pkg::l2_req_t req;
		logic [31:0] r;
		r = $urandom;
		req.unit = r[1:0];
		req.strand = r[3:2];
		req.way = r[5:4];
		req.op = op;
		r = $urandom;
		req.address = r[ADDR-1:0];
		for (int i = 0; i < LINE / 32; i++)
			req.data[i*32 +: 32] = $urandom;
		req.mask = {$urandom, $urandom};
		return req;
	endfunction

	task automatic report_mismatch(input string sig, input logic [623:0] exp,
		input logic [623:0] act);
		$display("Fail at %0t ns: %s expected %0h, got %0h", $time, sig, exp, act);
		err_count++;
	endtask

	task automatic report_error(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		err_count++;
	endtask

	// memory acks after 0 to 3 cycles, fills 1 to 6 cycles after the ack
	initial
	begin
		mem_req_ack = 1'b0;
		mem_fill_valid = 1'b0;
		mem_fill_data = '0;
		fill_pending = 1'b0;
		ack_wait = 0;
		fill_wait = 0;
		forever
		begin
			@(negedge clk);
			mem_req_ack = 1'b0;
			mem_fill_valid = 1'b0;
			if (fill_pending)
			begin
				fill_wait--;
				if (fill_wait == 0)
				begin
					mem_fill_valid = 1'b1;
					mem_fill_data = line_of(fill_addr);
					fill_pending = 1'b0;
				end
			end
			else if (mem_req_valid && !hold_ack && !rst)
			begin
				if (ack_wait == 0)
				begin
					mem_req_ack = 1'b1;
					fill_addr = mem_req_address;
					fill_wait = 1 + $urandom % 6;
					fill_pending = 1'b1;
					ack_wait = $urandom % 4;
				end
				else
					ack_wait--;
			end
		end
	end

	// the reference queue entry stays until the restart cycle ends
	always @(posedge clk)
	begin
		if (rst)
		begin
			model_count <= 0;
			way_next <= 2'd0;
			pop_pending <= 1'b0;
			exp_head_addr <= '0;
		end
		else
		begin
			push_ok = miss_valid && model_count < DEPTH;
			if (pci_valid && pci_ack && core_q.size() > 0)
				exp_core <= core_q.pop_front();
			if (pop_pending && miss_q.size() > 0)
				void'(miss_q.pop_front());
			if (mem_fill_valid && miss_q.size() > 0)
			begin
				exp_restart <= miss_q[0];
				exp_line <= line_of(miss_q[0].address);
				exp_way <= way_next;
				way_next <= way_next + 2'd1;
			end
			if (push_ok)
				miss_q.push_back(miss_drv);
			pop_pending <= mem_fill_valid;
			model_count <= model_count + (push_ok ? 1 : 0) - (pop_pending ? 1 : 0);
			exp_head_addr <= (miss_q.size() > 0) ? miss_q[0].address : '0;
		end
	end

	a_reset_low: assert property (@(posedge clk)
		$fell(rst) |-> !arb_pci_valid && !arb_has_sm_data && !mem_req_valid)
		else report_error("outputs not low right after reset");
	a_core_ack: assert property (@(posedge clk) disable iff (rst)
		pci_valid && !stall_pipeline && !$past(mem_fill_valid) |-> pci_ack)
		else report_error("core request not acked with no stall and no restart");
	a_stall_no_ack: assert property (@(posedge clk) disable iff (rst)
		stall_pipeline |-> !pci_ack)
		else report_error("core request acked during stall");
	a_restart_no_ack: assert property (@(posedge clk) disable iff (rst)
		mem_fill_valid |=> !pci_ack)
		else report_error("core request acked in the restart cycle");
	a_stall_no_out: assert property (@(posedge clk) disable iff (rst)
		stall_pipeline && !$past(mem_fill_valid) |=> !arb_pci_valid)
		else report_error("request entered the pipeline during stall");
	a_core_valid: assert property (@(posedge clk) disable iff (rst)
		pci_ack |=> arb_pci_valid && !arb_has_sm_data)
		else report_error("acked core request did not reach the pipeline");
	a_core_req: assert property (@(posedge clk) disable iff (rst)
		pci_ack |=> arb_req == exp_core)
		else report_mismatch("arb_pci_req", $sampled(exp_core), $sampled(arb_req));
	a_fill_valid: assert property (@(posedge clk) disable iff (rst)
		mem_fill_valid |-> ##2 arb_pci_valid && arb_has_sm_data)
		else report_error("memory fill did not restart two cycles later");
	a_fill_req: assert property (@(posedge clk) disable iff (rst)
		mem_fill_valid |-> ##2 arb_req == exp_restart)
		else report_mismatch("arb_pci_req", $sampled(exp_restart), $sampled(arb_req));
	a_fill_data: assert property (@(posedge clk) disable iff (rst)
		mem_fill_valid |-> ##2 arb_sm_data == exp_line)
		else report_mismatch("arb_sm_data", $sampled(exp_line), $sampled(arb_sm_data));
	a_fill_way: assert property (@(posedge clk) disable iff (rst)
		mem_fill_valid |-> ##2 arb_sm_fill_way == exp_way)
		else report_mismatch("arb_sm_fill_way", $sampled(exp_way),
			$sampled(arb_sm_fill_way));
	a_mem_addr: assert property (@(posedge clk) disable iff (rst)
		mem_req_valid |-> mem_req_address == exp_head_addr)
		else report_mismatch("mem_req_address", $sampled(exp_head_addr),
			$sampled(mem_req_address));
	a_full: assert property (@(posedge clk) disable iff (rst)
		miss_full == (model_count == DEPTH))
		else report_mismatch("miss_full", $sampled(model_count == DEPTH),
			$sampled(miss_full));

	task automatic send_core(input l2_pkg::l2_req_t req);
		int waited;
		waited = 0;
		@(negedge clk);
		core_drv = req;
		pci_valid = 1'b1;
		core_q.push_back(req);
		@(posedge clk);
		while (!pci_ack && waited < 100)
		begin
			waited++;
			@(posedge clk);
		end
		if (!pci_ack)
			report_error("core request was never acked");
		@(negedge clk);
		pci_valid = 1'b0;
	endtask

	task automatic push_miss(input l2_pkg::l2_req_t req);
		int waited;
		waited = 0;
		@(negedge clk);
		while (model_count >= DEPTH && waited < 200)
		begin
			waited++;
			@(negedge clk);
		end
		if (model_count >= DEPTH)
			report_error("miss queue stayed full");
		miss_drv = req;
		miss_valid = 1'b1;
		@(negedge clk);
		miss_valid = 1'b0;
	endtask

	task automatic wait_fill();
		int waited;
		waited = 0;
		@(posedge clk);
		while (!mem_fill_valid && waited < 100)
		begin
			waited++;
			@(posedge clk);
		end
		if (!mem_fill_valid)
			report_error("memory fill never arrived");
	endtask

	task automatic wait_drained();
		int waited;
		waited = 0;
		while (model_count != 0 && waited < 300)
		begin
			waited++;
			@(negedge clk);
		end
		if (model_count != 0)
			report_error("outstanding misses were not restarted");
		repeat (3) @(negedge clk);
	endtask

	task automatic finish_test(input string name, input int errs_before);
		if (err_count == errs_before)
			$display("test %s: passed", name);
		else
		begin
			$display("test %s: failed with %0d errors", name, err_count - errs_before);
			tests_failed++;
		end
	endtask

	initial
	begin
		int errs;
		void'($urandom(74235));
		rst = 1'b1;
		stall_pipeline = 1'b0;
		pci_valid = 1'b0;
		miss_valid = 1'b0;
		core_drv = '0;
		miss_drv = '0;
		hold_ack = 1'b0;
		err_count = 0;
		tests_failed = 0;

		errs = err_count;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		repeat (2) @(negedge clk);
		finish_test("reset", errs);

		errs = err_count;
		repeat (4) send_core(random_req(l2_pkg::OP_LOAD));
		finish_test("core_accept", errs);

		// restart goes through while the core waits out the stall
		errs = err_count;
		@(negedge clk);
		stall_pipeline = 1'b1;
		push_miss(random_req(l2_pkg::OP_LOAD));
		fork
			send_core(random_req(l2_pkg::OP_STORE));
			begin
				wait_fill();
				repeat (2) @(negedge clk);
				stall_pipeline = 1'b0;
			end
		join
		wait_drained();
		finish_test("stall", errs);

		// stall drops in the data_ready cycle, so only the restart blocks the ack
		errs = err_count;
		push_miss(random_req(l2_pkg::OP_STORE));
		@(negedge clk);
		stall_pipeline = 1'b1;
		fork
			send_core(random_req(l2_pkg::OP_LOAD));
			begin
				wait_fill();
				@(negedge clk);
				stall_pipeline = 1'b0;
			end
		join
		wait_drained();
		finish_test("restart_priority", errs);

		errs = err_count;
		fork
			for (int n = 0; n < 6; n++)
				push_miss(random_req(n[0] ? l2_pkg::OP_STORE : l2_pkg::OP_LOAD));
			repeat (8) send_core(random_req(l2_pkg::OP_STORE));
		join
		wait_drained();
		finish_test("restart_order", errs);

		errs = err_count;
		@(posedge clk);
		hold_ack = 1'b1;
		repeat (DEPTH) push_miss(random_req(l2_pkg::OP_LOAD));
		repeat (4) @(negedge clk);
		@(posedge clk);
		hold_ack = 1'b0;
		wait_drained();
		finish_test("queue_full", errs);

		$display("tests run %0d, tests failed %0d, errors %0d",
			NUM_TESTS, tests_failed, err_count);
		if (err_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		repeat (NUM_TESTS * 200) @(posedge clk);
		$display("watchdog: run did not finish within %0d cycles", NUM_TESTS * 200);
		$display("TEST FAILED");
		$finish;
	end

endmodule
